// File: cache.f
+incdir+.
lc3b_types.sv
cache_control.sv
cache_datapath.sv
cache.sv
cache_chk.sv
cache_tb.sv

// File: cache.sv
module cache
(
	input logic clk,
	input logic rst_n,

	input logic mem_read,
	input logic mem_write,
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_word mem_wdata,
	input lc3b_types::lc3b_mem_wmask mem_byte_enable,
	output lc3b_types::lc3b_word mem_rdata,
	output logic mem_resp,

	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_line pmem_wdata,
	input lc3b_types::lc3b_line pmem_rdata,
	input logic pmem_resp
);

	logic lru_write;
	logic data0_write, data1_write;
	logic tag0_write, tag1_write;
	logic valid0_write, valid1_write;
	logic dirty0_write, dirty1_write;
	logic lru_in, dirty0_in, dirty1_in;
	logic pmemmux_sel, writein_sel;
	logic hit, way0_out, way1_out;
	logic lru_out, dirty0_out, dirty1_out;

	cache_control control
	(
		.clk, .rst_n,
		.mem_read, .mem_write, .mem_byte_enable, .mem_resp,
		.hit, .way0_out, .way1_out, .lru_out, .dirty0_out, .dirty1_out,
		.lru_write, .data0_write, .data1_write, .tag0_write, .tag1_write,
		.valid0_write, .valid1_write, .dirty0_write, .dirty1_write,
		.lru_in, .dirty0_in, .dirty1_in, .pmemmux_sel, .writein_sel,
		.pmem_read, .pmem_write, .pmem_resp
	);

	cache_datapath datapath
	(
		.clk, .rst_n,
		.mem_address, .mem_wdata, .mem_byte_enable, .mem_rdata,
		.pmem_rdata, .pmem_address, .pmem_wdata,
		.lru_write, .data0_write, .data1_write, .tag0_write, .tag1_write,
		.valid0_write, .valid1_write, .dirty0_write, .dirty1_write,
		.lru_in, .dirty0_in, .dirty1_in, .pmemmux_sel, .writein_sel,
		.hit, .way0_out, .way1_out, .lru_out, .dirty0_out, .dirty1_out
	);

endmodule : cache

// File: cache_chk.sv
module cache_chk
(
	input logic clk,
	input logic rst_n,
	input logic mem_write,
	input lc3b_types::lc3b_mem_wmask mem_byte_enable,
	input logic mem_resp,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp
);

	int assert_errors = 0;                          // Read by the testbench

	strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(pmem_read && pmem_write))
	else
	begin
		assert_errors++;
		$error("pmem_read and pmem_write are high together");
	end

	write_mask_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		mem_write |-> mem_byte_enable != 2'b00)
	else
	begin
		assert_errors++;
		$error("write request with an all-zero byte mask");
	end

	read_held: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_read && !pmem_resp |=> pmem_read)
	else
	begin
		assert_errors++;
		$error("pmem_read dropped before pmem_resp");
	end

	write_held: assert property (@(posedge clk) disable iff (!rst_n)
		pmem_write && !pmem_resp |=> pmem_write)
	else
	begin
		assert_errors++;
		$error("pmem_write dropped before pmem_resp");
	end

	// Outputs quiet in the cycle after a reset edge
	quiet_after_reset: assert property (@(posedge clk)
		!rst_n |=> !mem_resp && !pmem_read && !pmem_write)
	else
	begin
		assert_errors++;
		$error("cache outputs active right after reset");
	end

endmodule : cache_chk

// File: cache_control.sv
module cache_control
(
	input logic clk,
	input logic rst_n,

	input logic mem_read,
	input logic mem_write,
	input lc3b_types::lc3b_mem_wmask mem_byte_enable,
	output logic mem_resp,

	input logic hit,
	input logic way0_out,
	input logic way1_out,
	input logic lru_out,
	input logic dirty0_out,
	input logic dirty1_out,

	output logic lru_write,
	output logic data0_write,
	output logic data1_write,
	output logic tag0_write,
	output logic tag1_write,
	output logic valid0_write,
	output logic valid1_write,
	output logic dirty0_write,
	output logic dirty1_write,

	output logic lru_in,
	output logic dirty0_in,
	output logic dirty1_in,

	output logic pmemmux_sel,
	output logic writein_sel,

	output logic pmem_read,
	output logic pmem_write,
	input logic pmem_resp
);

	typedef enum logic [2:0]
	{
		s_idle,
		s_writeback,
		s_allocate,
		s_writemiss,
		s_lruupdate
	} state_t;

	state_t state;
	state_t next_state;

	logic request;
	logic victim_dirty;

	assign request = mem_read | mem_write;
	assign victim_dirty = lru_out ? dirty1_out : dirty0_out;

	always_comb
	begin
		lru_write = 1'b0;
		data0_write = 1'b0;
		data1_write = 1'b0;
		tag0_write = 1'b0;
		tag1_write = 1'b0;
		valid0_write = 1'b0;
		valid1_write = 1'b0;
		dirty0_write = 1'b0;
		dirty1_write = 1'b0;
		lru_in = 1'b0;
		dirty0_in = 1'b0;
		dirty1_in = 1'b0;
		pmemmux_sel = 1'b0;
		writein_sel = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		mem_resp = 1'b0;

		case (state)
			s_idle:
			begin
				if (hit && (mem_read || (mem_write && mem_byte_enable != 2'b00)))
				begin
					mem_resp = 1'b1;
					lru_write = 1'b1;
					writein_sel = mem_write;           // Merge under the mask
					if (way0_out)
					begin
						lru_in = 1'b1;                  // Way 1 becomes the victim
						data0_write = mem_write;
						dirty0_write = mem_write;
						dirty0_in = 1'b1;
					end
					else if (way1_out)
					begin
						lru_in = 1'b0;
						data1_write = mem_write;
						dirty1_write = mem_write;
						dirty1_in = 1'b1;
					end
				end
			end

			s_writeback:
			begin
				pmemmux_sel = 1'b1;                     // Victim tag with the index
				pmem_write = 1'b1;
			end

			s_allocate:
			begin
				pmem_read = 1'b1;
				if (pmem_resp)
				begin
					// Fill the victim way with a clean line
					if (lru_out)
					begin
						data1_write = 1'b1;
						tag1_write = 1'b1;
						valid1_write = 1'b1;
						dirty1_write = 1'b1;
						dirty1_in = 1'b0;
					end
					else
					begin
						data0_write = 1'b1;
						tag0_write = 1'b1;
						valid0_write = 1'b1;
						dirty0_write = 1'b1;
						dirty0_in = 1'b0;
					end
				end
			end

			s_writemiss:
			begin
				if (mem_write)
				begin
					writein_sel = 1'b1;
					if (lru_out)
					begin
						data1_write = 1'b1;
						dirty1_write = 1'b1;
						dirty1_in = 1'b1;
					end
					else
					begin
						data0_write = 1'b1;
						dirty0_write = 1'b1;
						dirty0_in = 1'b1;
					end
				end
			end

			s_lruupdate:
			begin
				mem_resp = 1'b1;
				lru_write = 1'b1;
				lru_in = ~lru_out;                      // Filled way is now most recent
			end

			default:
			begin
				mem_resp = 1'b0;
			end
		endcase
	end

	always_comb
	begin
		next_state = state;
		case (state)
			s_idle:
			begin
				if (request && !hit)
					next_state = victim_dirty ? s_writeback : s_allocate;
			end
			s_writeback:
			begin
				if (pmem_resp)
					next_state = s_allocate;
			end
			s_allocate:
			begin
				if (pmem_resp)
					next_state = s_writemiss;
			end
			s_writemiss:
				next_state = s_lruupdate;
			s_lruupdate:
				next_state = s_idle;
			default:
				next_state = s_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= s_idle;
		else
			state <= next_state;
	end

endmodule : cache_control

// File: cache_datapath.sv
`include "lc3b_cache_settings.svh"

module cache_datapath
(
	input logic clk,
	input logic rst_n,

	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_word mem_wdata,
	input lc3b_types::lc3b_mem_wmask mem_byte_enable,
	output lc3b_types::lc3b_word mem_rdata,

	input lc3b_types::lc3b_line pmem_rdata,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_line pmem_wdata,

	input logic lru_write,
	input logic data0_write,
	input logic data1_write,
	input logic tag0_write,
	input logic tag1_write,
	input logic valid0_write,
	input logic valid1_write,
	input logic dirty0_write,
	input logic dirty1_write,

	input logic lru_in,
	input logic dirty0_in,
	input logic dirty1_in,
	input logic pmemmux_sel,
	input logic writein_sel,

	output logic hit,
	output logic way0_out,
	output logic way1_out,
	output logic lru_out,
	output logic dirty0_out,
	output logic dirty1_out
);

	import lc3b_types::*;

	logic [`CACHE_SETS-1:0] valid0;
	logic [`CACHE_SETS-1:0] valid1;
	logic [`CACHE_SETS-1:0] dirty0;
	logic [`CACHE_SETS-1:0] dirty1;
	logic [`CACHE_SETS-1:0] lru;                     // 1 means way 1 is the victim
	lc3b_tag tag0 [`CACHE_SETS];
	lc3b_tag tag1 [`CACHE_SETS];
	lc3b_line data0 [`CACHE_SETS];
	lc3b_line data1 [`CACHE_SETS];

	lc3b_cache_addr addr;
	lc3b_cache_addr line_addr;
	lc3b_index idx;
	logic [`CACHE_OFFSET_BITS-2:0] word_sel;
	lc3b_tag victim_tag;
	lc3b_line hit_line;
	lc3b_line base_line;
	lc3b_line merged_line;
	lc3b_line write_line;

	assign addr.word = mem_address;
	assign idx = addr.f.index;
	assign word_sel = addr.f.offset[`CACHE_OFFSET_BITS-1:1];

	// Tag compare on both ways
	assign way0_out = valid0[idx] && (tag0[idx] == addr.f.tag);
	assign way1_out = valid1[idx] && (tag1[idx] == addr.f.tag);
	assign hit = way0_out | way1_out;

	assign lru_out = lru[idx];
	assign dirty0_out = dirty0[idx];
	assign dirty1_out = dirty1[idx];

	assign hit_line = way1_out ? data1[idx] : data0[idx];
	assign mem_rdata = hit_line[word_sel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];

	// Hit way on a hit, the freshly filled victim otherwise
	assign base_line = (hit ? way1_out : lru_out) ? data1[idx] : data0[idx];

	always_comb
	begin
		merged_line = base_line;
		if (mem_byte_enable[0])
			merged_line[word_sel*`CACHE_WORD_BITS +: 8] = mem_wdata[7:0];
		if (mem_byte_enable[1])
			merged_line[word_sel*`CACHE_WORD_BITS + 8 +: 8] = mem_wdata[15:8];
	end

	assign write_line = writein_sel ? merged_line : pmem_rdata;

	// Victim line and the line-aligned memory address
	assign victim_tag = lru_out ? tag1[idx] : tag0[idx];
	assign pmem_wdata = lru_out ? data1[idx] : data0[idx];

	always_comb
	begin
		line_addr.f.tag = pmemmux_sel ? victim_tag : addr.f.tag;
		line_addr.f.index = idx;
		line_addr.f.offset = '0;
	end

	assign pmem_address = line_addr.word;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			valid0 <= '0;
			valid1 <= '0;
			dirty0 <= '0;
			dirty1 <= '0;
			lru <= '0;
		end
		else
		begin
			if (valid0_write)
				valid0[idx] <= 1'b1;
			if (valid1_write)
				valid1[idx] <= 1'b1;
			if (dirty0_write)
				dirty0[idx] <= dirty0_in;
			if (dirty1_write)
				dirty1[idx] <= dirty1_in;
			if (lru_write)
				lru[idx] <= lru_in;
		end
	end

	always_ff @(posedge clk)
	begin
		if (tag0_write)
			tag0[idx] <= addr.f.tag;
		if (tag1_write)
			tag1[idx] <= addr.f.tag;
		if (data0_write)
			data0[idx] <= write_line;
		if (data1_write)
			data1[idx] <= write_line;
	end

endmodule : cache_datapath

// File: cache_tb.sv
module cache_tb;

	import lc3b_types::*;

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	lc3b_word mem_address;
	lc3b_word mem_wdata;
	lc3b_mem_wmask mem_byte_enable;
	lc3b_word mem_rdata;
	logic mem_resp;
	logic pmem_read;
	logic pmem_write;
	lc3b_word pmem_address;
	lc3b_line pmem_wdata;
	lc3b_line pmem_rdata;
	logic pmem_resp;

	lc3b_line phys [4096];                           // Physical memory with one entry per line
	lc3b_word shadow [32768];                        // Expected contents with one entry per word
	int errors;
	int tests_run;
	int tests_failed;
	int test_start_errors;
	int wb_count;
	lc3b_word wb_addr;
	logic saw_read;
	logic saw_write;
	lc3b_word read_addr;

	cache dut (.*);

	bind cache cache_chk chk (.*);

	always #50 clk = ~clk;

	function automatic lc3b_word fill_word(int word_index);
		return lc3b_word'(word_index * 40503) ^ 16'h3c5a;
	endfunction

	function automatic lc3b_word apply_mask(lc3b_word old_word, lc3b_word new_word,
		lc3b_mem_wmask mask);
		lc3b_word merged;
		merged = old_word;
		if (mask[0])
			merged[7:0] = new_word[7:0];
		if (mask[1])
			merged[15:8] = new_word[15:8];
		return merged;
	endfunction

	function automatic lc3b_word expected_word(lc3b_word addr);
		return shadow[addr[15:1]];
	endfunction

	function automatic lc3b_line shadow_line(lc3b_word addr);
		lc3b_line line;
		int w;
		for (w = 0; w < 8; w++)
			line[w*16 +: 16] = shadow[{addr[15:4], w[2:0]}];
		return line;
	endfunction

	function automatic lc3b_word make_addr(lc3b_tag tag, lc3b_index index, lc3b_offset offset);
		lc3b_cache_addr a;
		a.f.tag = tag;
		a.f.index = index;
		a.f.offset = offset;
		return a.word;
	endfunction

	function automatic int total_errors();
		return errors + dut.chk.assert_errors;
	endfunction

	task automatic check_word(string name, lc3b_word got, lc3b_word expected);
		if (got !== expected)
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_line(string name, lc3b_line got, lc3b_line expected);
		if (got !== expected)
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic check_bit(string name, logic got, logic expected);
		if (got !== expected)
		begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic report_problem(string what);
		errors++;
		$display("Error: %s", what);
	endtask

	task automatic end_test(string name);
		int n;
		n = total_errors() - test_start_errors;
		tests_run++;
		if (n == 0)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, n);
		end
		test_start_errors = total_errors();
	endtask

	task automatic note_strobes();
		if (pmem_read === 1'b1)
		begin
			saw_read = 1'b1;
			read_addr = pmem_address;
		end
		if (pmem_write === 1'b1)
			saw_write = 1'b1;
	endtask

	// Entered and left 10 units after a rising edge
	task automatic cpu_access(input logic wr, input lc3b_word addr, input lc3b_word data,
		input lc3b_mem_wmask mask, output int cycles);
		int n;
		mem_read = ~wr;
		mem_write = wr;
		mem_address = addr;
		mem_wdata = data;
		mem_byte_enable = mask;
		saw_read = 1'b0;
		saw_write = 1'b0;
		n = 0;
		@(negedge clk);
		note_strobes();
		while (mem_resp !== 1'b1 && n < 200)
		begin
			n++;
			@(negedge clk);
			note_strobes();
		end
		if (mem_resp !== 1'b1)
		begin
			$display("Timed out after %0d cycles waiting for mem_resp at address %h", n, addr);
			$display(">>> FAIL");
			$finish;
		end
		else
		begin
			cycles = n;
			if (wr)
				shadow[addr[15:1]] = apply_mask(shadow[addr[15:1]], data, mask);
			@(posedge clk);
			#10;
			mem_read = 1'b0;
			mem_write = 1'b0;
		end
	endtask

	task automatic write_read(lc3b_word addr, lc3b_word data, lc3b_mem_wmask mask);
		int cycles;
		cpu_access(1'b1, addr, data, mask, cycles);
		cpu_access(1'b0, addr, 16'h0000, 2'b11, cycles);
		if (cycles != 0)
			report_problem("read right after a write did not hit");
	endtask

	// Line memory answering each strobe after 1 to 4 cycles
	always
	begin : phys_mem
		int delay;
		@(negedge clk);
		if (rst_n && (pmem_read || pmem_write))
		begin
			delay = $urandom_range(4, 1);
			repeat (delay) @(posedge clk);
			#10;
			if (pmem_write)
			begin
				check_word("pmem_address[3:0]", {12'h000, pmem_address[3:0]}, 16'h0000);
				check_line("pmem_wdata", pmem_wdata, shadow_line(pmem_address));
				phys[pmem_address[15:4]] = pmem_wdata;
				wb_count++;
				wb_addr = pmem_address;
			end
			else
			begin
				check_word("pmem_address", pmem_address, mem_address & 16'hfff0);  // Request's line
				pmem_rdata = phys[pmem_address[15:4]];
			end
			pmem_resp = 1'b1;
			@(posedge clk);
			#10;
			pmem_resp = 1'b0;
		end
	end

	// Every read response against the reference
	always @(negedge clk)
	begin
		if (rst_n && mem_resp && mem_read)
			check_word("mem_rdata", mem_rdata, expected_word(mem_address));
	end

	initial
	begin
		int cycles;
		int i;
		int base;
		lc3b_word a;
		lc3b_word b;
		lc3b_word c;
		void'($urandom(17638));
		clk = 1'b0;
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		mem_byte_enable = 2'b11;
		pmem_rdata = '0;
		pmem_resp = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start_errors = 0;
		wb_count = 0;
		wb_addr = '0;
		for (i = 0; i < 32768; i++)
			shadow[i] = fill_word(i);
		for (i = 0; i < 4096; i++)
			phys[i] = shadow_line(lc3b_word'(i * 16));

		repeat (3) @(posedge clk);
		#10;
		rst_n = 1'b1;
		@(negedge clk);
		check_bit("mem_resp", mem_resp, 1'b0);
		check_bit("pmem_read", pmem_read, 1'b0);
		check_bit("pmem_write", pmem_write, 1'b0);
		end_test("reset");
		@(posedge clk);
		#10;

		cpu_access(1'b0, make_addr(9'h004, 3'd0, 4'h6), 16'h0000, 2'b11, cycles);
		check_bit("pmem_read", saw_read, 1'b1);
		check_word("pmem_address", read_addr, make_addr(9'h004, 3'd0, 4'h0));
		end_test("read miss");

		cpu_access(1'b0, make_addr(9'h004, 3'd0, 4'hc), 16'h0000, 2'b11, cycles);
		if (cycles != 0)
			report_problem("read hit did not respond in the cycle it was presented");
		check_bit("pmem_read", saw_read, 1'b0);
		check_bit("pmem_write", saw_write, 1'b0);
		end_test("read hit");

		write_read(make_addr(9'h012, 3'd3, 4'h2), 16'ha1b2, 2'b01);   // Write miss
		write_read(make_addr(9'h012, 3'd3, 4'h2), 16'hc3d4, 2'b10);
		write_read(make_addr(9'h012, 3'd3, 4'h8), 16'he5f6, 2'b11);
		write_read(make_addr(9'h024, 3'd3, 4'ha), 16'h1357, 2'b10);   // Other way
		end_test("write masks");

		a = make_addr(9'h030, 3'd5, 4'h4);
		b = make_addr(9'h031, 3'd5, 4'h6);
		c = make_addr(9'h032, 3'd5, 4'h0);
		base = wb_count;
		cpu_access(1'b1, a, 16'h2468, 2'b11, cycles);
		cpu_access(1'b1, b, 16'h9bdf, 2'b01, cycles);
		cpu_access(1'b0, c, 16'h0000, 2'b11, cycles);
		if (wb_count != base + 1)
			report_problem("no writeback of the least recently used way");
		check_word("pmem_address", wb_addr, a & 16'hfff0);
		cpu_access(1'b0, b, 16'h0000, 2'b11, cycles);
		cpu_access(1'b0, a, 16'h0000, 2'b11, cycles);                // Evicts clean c
		if (wb_count != base + 1)
			report_problem("clean line was written back");
		cpu_access(1'b0, c, 16'h0000, 2'b11, cycles);
		if (wb_count != base + 2)
			report_problem("no writeback of the dirty victim");
		check_word("pmem_address", wb_addr, b & 16'hfff0);
		end_test("conflict eviction");

		for (i = 0; i < 300; i++)
		begin
			a = lc3b_word'($urandom_range(16'h07ff, 0)) & 16'hfffe;
			b = lc3b_word'($urandom);
			cpu_access(1'($urandom_range(1, 0)), a, b, 2'($urandom_range(3, 1)), cycles);
		end
		end_test("random mix");

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
		if (total_errors() == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule : cache_tb

// File: lc3b_cache_settings.svh
`ifndef LC3B_CACHE_SETTINGS_SVH
`define LC3B_CACHE_SETTINGS_SVH

// CPU word and memory line sizes
`define CACHE_WORD_BITS 16
`define CACHE_LINE_BITS 128

// Two ways of eight sets each
`define CACHE_SETS 8

// Address split, tag high and byte offset low
`define CACHE_OFFSET_BITS 4
`define CACHE_INDEX_BITS 3
`define CACHE_TAG_BITS 9

`endif

// File: lc3b_types.sv
`include "lc3b_cache_settings.svh"

package lc3b_types;

	// CPU side word and its byte mask
	typedef logic [`CACHE_WORD_BITS-1:0] lc3b_word;
	typedef logic [1:0] lc3b_mem_wmask;            // Bit 0 is the low byte

	// Eight words, word 0 in the low bits
	typedef logic [`CACHE_LINE_BITS-1:0] lc3b_line;

	typedef logic [`CACHE_TAG_BITS-1:0] lc3b_tag;
	typedef logic [`CACHE_INDEX_BITS-1:0] lc3b_index;
	typedef logic [`CACHE_OFFSET_BITS-1:0] lc3b_offset;

	typedef struct packed
	{
		lc3b_tag tag;
		lc3b_index index;
		lc3b_offset offset;                         // Bits 3:1 pick the word
	} lc3b_addr_fields;

	// Address seen either as one word or as its cache fields
	typedef union packed
	{
		lc3b_word word;
		lc3b_addr_fields f;
	} lc3b_cache_addr;

endpackage : lc3b_types
